// File: compile.f
+incdir+source
source/madam_pkg.sv
source/madam_regs.sv
source/matrix_sequencer.sv
source/matrix_mac.sv
source/madam_top.sv
test/madam_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the MADAM testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module madam_tb \
	-Mdir obj_dir -o madam_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/madam_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

// File: source/madam_consts.svh
/*
 * MADAM constants shared by the RTL and the testbench.
 * register addresses on the 16-bit CPU bus, fixed read values,
 * reset values and the fixed-point fraction width of the matrix engine.
 */
`ifndef MADAM_CONSTS_SVH
`define MADAM_CONSTS_SVH

// fixed read values.
`define MADAM_REVISION		32'h01020000	// chip revision word.
`define MADAM_MSYSBITS		32'h00000029	// 2 MB DRAM, 1 MB VRAM.
`define MADAM_MCTL_RESET	32'h00002000	// dma enables out of reset.
`define MADAM_BAD_READ		32'hBADACCE5	// what an unmapped address returns.

// control and status registers.
`define ADDR_REVISION		16'h0000
`define ADDR_MSYSBITS		16'h0004
`define ADDR_MCTL			16'h0008
`define ADDR_SLTIME			16'h000C
`define ADDR_MSB_CHECK		16'h002C	// highest set bit finder.
`define ADDR_REGCTL0		16'h0130	// regctl1 to regctl3 follow at +4 steps.

// matrix engine window.
`define ADDR_MATRIX_BASE	16'h0600	// 16 words, row major.
`define ADDR_VECTOR_BASE	16'h0640	// 4 words.
`define ADDR_REZ_BASE		16'h0660	// 4 result words.
`define ADDR_MATRIX_CMD		16'h07FC	// command on write, busy on read.

// operands and results are 16.16 fixed point.
`define MATRIX_FRAC_BITS	16

// msb finder result for an all-zero word.
`define MSB_NONE			32'hFFFFFFFF

`endif

// File: source/madam_pkg.sv
/*
 * MADAM types.
 * word_t       cpu and register word, also read signed as 16.16.
 * product_t    full signed product of two 16.16 words.
 * row_idx_t    matrix row and result index.
 * matrix_cmd_t matrix engine command codes.
 */
package madam_pkg;

	// one bus / register word.
	typedef logic [31:0] word_t;

	// 32x32 signed product, kept at full width.
	typedef logic signed [63:0] product_t;

	// picks one of four matrix rows or result words.
	typedef logic [1:0] row_idx_t;

	// low two bits written to the command register.
	typedef enum logic [1:0] {
		nop   = 2'd0,	// no operation.
		mul4  = 2'd1,	// 4x4 matrix times 4-vector.
		mul3  = 2'd2,	// 3x3 matrix times 3-vector.
		persp = 2'd3	// perspective divide, not built, acts as nop.
	} matrix_cmd_t;

endpackage

// File: source/madam_regs.sv
/*
 * MADAM register block.
 * cpu write decode and register storage, combinational read mux,
 * msb finder, command strobe to the sequencer, operand row select
 * for the multiply pipeline and result write-back.
 */
`timescale 1ns/1ps
`include "madam_consts.svh"

module madam_regs (
	input  logic                    clk_25m,
	input  logic                    reset_n,
	input  logic [15:0]             cpu_addr,
	input  madam_pkg::word_t        cpu_din,
	input  logic                    cpu_wr,
	output madam_pkg::word_t        cpu_dout,
	output logic                    cmd_strobe,	// one cycle after a 0x7FC write.
	output madam_pkg::matrix_cmd_t  cmd,
	input  logic                    busy,
	input  madam_pkg::row_idx_t     row_idx,
	output madam_pkg::word_t        row_m0,
	output madam_pkg::word_t        row_m1,
	output madam_pkg::word_t        row_m2,
	output madam_pkg::word_t        row_m3,
	output madam_pkg::word_t        vec0,
	output madam_pkg::word_t        vec1,
	output madam_pkg::word_t        vec2,
	output madam_pkg::word_t        vec3,
	input  logic                    rez_valid,
	input  madam_pkg::row_idx_t     rez_idx,
	input  madam_pkg::word_t        rez_value
);

	// window masks keep the page bits and the byte lane but drop the word index.
	localparam logic [15:0] MATRIX_MASK = 16'hFFC3;
	localparam logic [15:0] VECTOR_MASK = 16'hFFF3;

	madam_pkg::word_t sltime;
	madam_pkg::word_t msb_check;	// word searched by the msb finder.
	madam_pkg::word_t regctl [4];
	madam_pkg::word_t matrix [16];	// m00..m33 in row major order.
	madam_pkg::word_t vector [4];
	madam_pkg::word_t rez [4];		// written by the pipeline only.
	madam_pkg::word_t msb_index;

	logic matrix_hit;
	logic vector_hit;
	logic rez_hit;

	assign matrix_hit = (cpu_addr & MATRIX_MASK) == `ADDR_MATRIX_BASE;
	assign vector_hit = (cpu_addr & VECTOR_MASK) == `ADDR_VECTOR_BASE;
	assign rez_hit    = (cpu_addr & VECTOR_MASK) == `ADDR_REZ_BASE;

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			sltime     <= '0;
			msb_check  <= '0;
			cmd_strobe <= 1'b0;
			cmd        <= madam_pkg::nop;
			for (int i = 0; i < 4; i++) begin
				regctl[i] <= '0;
				vector[i] <= '0;
				rez[i]    <= '0;
			end
			for (int i = 0; i < 16; i++) begin
				matrix[i] <= '0;
			end
		end else begin
			cmd_strobe <= 1'b0;	// strobe lasts a single cycle.
			if (cpu_wr) begin
				case (cpu_addr)
					`ADDR_SLTIME:             sltime    <= cpu_din;
					`ADDR_MSB_CHECK:          msb_check <= cpu_din;
					`ADDR_REGCTL0:            regctl[0] <= cpu_din;
					`ADDR_REGCTL0 + 16'd4:    regctl[1] <= cpu_din;
					`ADDR_REGCTL0 + 16'd8:    regctl[2] <= cpu_din;
					`ADDR_REGCTL0 + 16'd12:   regctl[3] <= cpu_din;
					`ADDR_MATRIX_CMD: begin
						// the sequencer decides whether the command is taken.
						cmd_strobe <= 1'b1;
						cmd        <= madam_pkg::matrix_cmd_t'(cpu_din[1:0]);
					end
					default: begin
						if (matrix_hit)
							matrix[cpu_addr[5:2]] <= cpu_din;
						else if (vector_hit)
							vector[cpu_addr[3:2]] <= cpu_din;
						// revision, msysbits, mctl, rez and holes drop the write.
					end
				endcase
			end
			if (rez_valid)
				rez[rez_idx] <= rez_value;	// result write-back.
		end
	end

	// msb finder scans upward so the highest set bit wins.
	always_comb begin
		msb_index = `MSB_NONE;
		for (int i = 0; i < 32; i++) begin
			if (msb_check[i])
				msb_index = madam_pkg::word_t'(i);
		end
	end

	// operands for the row being issued.
	assign row_m0 = matrix[{row_idx, 2'd0}];
	assign row_m1 = matrix[{row_idx, 2'd1}];
	assign row_m2 = matrix[{row_idx, 2'd2}];
	assign row_m3 = matrix[{row_idx, 2'd3}];
	assign vec0   = vector[0];	// same vector for every row.
	assign vec1   = vector[1];
	assign vec2   = vector[2];
	assign vec3   = vector[3];

	// read mux follows cpu_addr without a clock.
	always_comb begin
		cpu_dout = `MADAM_BAD_READ;
		case (cpu_addr)
			`ADDR_REVISION:           cpu_dout = `MADAM_REVISION;
			`ADDR_MSYSBITS:           cpu_dout = `MADAM_MSYSBITS;
			`ADDR_MCTL:               cpu_dout = `MADAM_MCTL_RESET;	// read only.
			`ADDR_SLTIME:             cpu_dout = sltime;
			`ADDR_MSB_CHECK:          cpu_dout = msb_index;
			`ADDR_REGCTL0:            cpu_dout = regctl[0];
			`ADDR_REGCTL0 + 16'd4:    cpu_dout = regctl[1];
			`ADDR_REGCTL0 + 16'd8:    cpu_dout = regctl[2];
			`ADDR_REGCTL0 + 16'd12:   cpu_dout = regctl[3];
			`ADDR_MATRIX_CMD:         cpu_dout = {31'd0, busy};	// 0 once the engine is done.
			default: begin
				if (matrix_hit)
					cpu_dout = matrix[cpu_addr[5:2]];
				else if (vector_hit)
					cpu_dout = vector[cpu_addr[3:2]];
				else if (rez_hit)
					cpu_dout = rez[cpu_addr[3:2]];
			end
		endcase
	end

endmodule

// File: source/madam_top.sv
/*
 * MADAM top level.
 * register block, matrix sequencer and multiply pipeline,
 * joined by wires only.
 */
`timescale 1ns/1ps

module madam_top (
	input  logic              clk_25m,
	input  logic              reset_n,
	input  logic [15:0]       cpu_addr,
	input  madam_pkg::word_t  cpu_din,
	input  logic              cpu_wr,
	output madam_pkg::word_t  cpu_dout
);

	// regs to sequencer.
	logic cmd_strobe;
	madam_pkg::matrix_cmd_t cmd;
	logic busy;

	// sequencer to pipeline and operand select.
	logic row_valid;
	madam_pkg::row_idx_t row_idx;
	logic three_by_three;

	// operands for the issued row.
	madam_pkg::word_t row_m0;
	madam_pkg::word_t row_m1;
	madam_pkg::word_t row_m2;
	madam_pkg::word_t row_m3;
	madam_pkg::word_t vec0;
	madam_pkg::word_t vec1;
	madam_pkg::word_t vec2;
	madam_pkg::word_t vec3;

	// results back to the register block.
	logic rez_valid;
	madam_pkg::row_idx_t rez_idx;
	madam_pkg::word_t rez_value;

	madam_regs i_madam_regs (
		.clk_25m    (clk_25m),
		.reset_n    (reset_n),
		.cpu_addr   (cpu_addr),
		.cpu_din    (cpu_din),
		.cpu_wr     (cpu_wr),
		.cpu_dout   (cpu_dout),
		.cmd_strobe (cmd_strobe),
		.cmd        (cmd),
		.busy       (busy),
		.row_idx    (row_idx),
		.row_m0     (row_m0),
		.row_m1     (row_m1),
		.row_m2     (row_m2),
		.row_m3     (row_m3),
		.vec0       (vec0),
		.vec1       (vec1),
		.vec2       (vec2),
		.vec3       (vec3),
		.rez_valid  (rez_valid),
		.rez_idx    (rez_idx),
		.rez_value  (rez_value)
	);

	matrix_sequencer i_matrix_sequencer (
		.clk_25m        (clk_25m),
		.reset_n        (reset_n),
		.cmd_strobe     (cmd_strobe),
		.cmd            (cmd),
		.row_valid      (row_valid),
		.row_idx        (row_idx),
		.three_by_three (three_by_three),
		.busy           (busy)
	);

	matrix_mac i_matrix_mac (
		.clk_25m        (clk_25m),
		.reset_n        (reset_n),
		.row_valid      (row_valid),
		.row_idx        (row_idx),
		.three_by_three (three_by_three),
		.row_m0         (row_m0),
		.row_m1         (row_m1),
		.row_m2         (row_m2),
		.row_m3         (row_m3),
		.vec0           (vec0),
		.vec1           (vec1),
		.vec2           (vec2),
		.vec3           (vec3),
		.rez_valid      (rez_valid),
		.rez_idx        (rez_idx),
		.rez_value      (rez_value)
	);

endmodule

// File: source/matrix_mac.sv
/*
 * Matrix multiply pipeline, one row per cycle.
 * stage one: four signed 16.16 products, fourth zeroed for 3x3.
 * stage two: sum, arithmetic shift by the fraction width, truncate.
 */
`timescale 1ns/1ps
`include "madam_consts.svh"

module matrix_mac (
	input  logic                 clk_25m,
	input  logic                 reset_n,
	input  logic                 row_valid,
	input  madam_pkg::row_idx_t  row_idx,
	input  logic                 three_by_three,
	input  madam_pkg::word_t     row_m0,
	input  madam_pkg::word_t     row_m1,
	input  madam_pkg::word_t     row_m2,
	input  madam_pkg::word_t     row_m3,
	input  madam_pkg::word_t     vec0,
	input  madam_pkg::word_t     vec1,
	input  madam_pkg::word_t     vec2,
	input  madam_pkg::word_t     vec3,
	output logic                 rez_valid,
	output madam_pkg::row_idx_t  rez_idx,
	output madam_pkg::word_t     rez_value
);

	// signed 32x32 multiply at full 64-bit width.
	function automatic madam_pkg::product_t mul_q16(input madam_pkg::word_t a,
			input madam_pkg::word_t b);
		madam_pkg::product_t wa;
		madam_pkg::product_t wb;
		wa = $signed(a);	// sign extends.
		wb = $signed(b);
		return wa * wb;
	endfunction

	madam_pkg::product_t prod0;
	madam_pkg::product_t prod1;
	madam_pkg::product_t prod2;
	madam_pkg::product_t prod3;
	madam_pkg::product_t sum;
	madam_pkg::product_t scaled;
	madam_pkg::row_idx_t prod_idx;	// row index beside the products.
	logic prod_valid;

	assign sum    = prod0 + prod1 + prod2 + prod3;
	assign scaled = sum >>> `MATRIX_FRAC_BITS;	// back to 16.16.

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			prod_valid <= 1'b0;
			rez_valid  <= 1'b0;
		end else begin
			prod_valid <= row_valid;
			rez_valid  <= prod_valid;
		end
	end

	// data only moves with its valid.
	always_ff @(posedge clk_25m) begin
		if (row_valid) begin
			prod_idx <= row_idx;
			prod0    <= mul_q16(row_m0, vec0);
			prod1    <= mul_q16(row_m1, vec1);
			prod2    <= mul_q16(row_m2, vec2);
			prod3    <= three_by_three ? '0 : mul_q16(row_m3, vec3);
		end
		if (prod_valid) begin
			rez_idx   <= prod_idx;
			rez_value <= scaled[31:0];	// truncate to a word.
		end
	end

endmodule

// File: source/matrix_sequencer.sv
/*
 * Matrix command sequencer.
 * takes mul4 / mul3 when idle, issues one row per cycle,
 * and holds busy until the last result is written back.
 */
`timescale 1ns/1ps

module matrix_sequencer (
	input  logic                    clk_25m,
	input  logic                    reset_n,
	input  logic                    cmd_strobe,
	input  madam_pkg::matrix_cmd_t  cmd,
	output logic                    row_valid,
	output madam_pkg::row_idx_t     row_idx,
	output logic                    three_by_three,
	output logic                    busy
);

	madam_pkg::row_idx_t last_row;
	logic [2:0] step;	// edges since the command was taken.
	logic accept;

	assign last_row = three_by_three ? 2'd2 : 2'd3;
	assign accept   = cmd_strobe && !busy &&
		(cmd == madam_pkg::mul4 || cmd == madam_pkg::mul3);

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			row_valid      <= 1'b0;
			row_idx        <= '0;
			three_by_three <= 1'b0;
			busy           <= 1'b0;
			step           <= '0;
		end else if (accept) begin
			row_valid      <= 1'b1;	// row 0 goes out right away.
			row_idx        <= '0;
			three_by_three <= (cmd == madam_pkg::mul3);
			busy           <= 1'b1;
			step           <= '0;
		end else if (busy) begin
			step <= step + 3'd1;
			if (row_valid) begin
				if (row_idx == last_row)
					row_valid <= 1'b0;	// all rows issued.
				else
					row_idx <= row_idx + 2'd1;
			end
			// last row needs three more edges to land in rez.
			if (step == {1'b0, last_row} + 3'd2)
				busy <= 1'b0;
		end
	end

endmodule

// File: test/madam_tb.sv
/*
 * Testbench for the MADAM register bus and matrix engine.
 * reference model of the registers and the 16.16 matrix rule,
 * random stimulus, compare task and watchdog.
 */
`timescale 1ns/1ps
`include "madam_consts.svh"

module madam_tb;

	localparam int CLK_PERIOD = 40;
	localparam int N_ITER = 40;		// random register and msb passes.
	localparam int MUL_ROUNDS = 8;	// operand sets per command type.
	localparam int POLL_LIMIT = 32;
	// watchdog limit in cycles with plenty of margin.
	localparam int TIMEOUT_CYCLES = 2000 + N_ITER * 20 + MUL_ROUNDS * 400;

	logic clk_25m = 1'b0;
	logic reset_n;
	logic [15:0] cpu_addr;
	madam_pkg::word_t cpu_din;
	logic cpu_wr;
	madam_pkg::word_t cpu_dout;

	// model state.
	logic [31:0] model_sltime;
	logic [31:0] model_msb;
	logic [31:0] model_regctl [4];
	logic [31:0] model_m [16];
	logic [31:0] model_v [4];
	logic [31:0] model_rez [4];
	int errors = 0;
	int checks = 0;

	madam_top i_madam_top (
		.clk_25m  (clk_25m),
		.reset_n  (reset_n),
		.cpu_addr (cpu_addr),
		.cpu_din  (cpu_din),
		.cpu_wr   (cpu_wr),
		.cpu_dout (cpu_dout)
	);

	always #(CLK_PERIOD / 2) clk_25m = ~clk_25m;

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s got 0x%08h expected 0x%08h",
				$time, name, actual, expected);
		end
	endtask

	// one-cycle write strobe dropped right after the sampling edge.
	task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
		@(posedge clk_25m);
		#1;
		cpu_addr = addr;
		cpu_din  = data;
		cpu_wr   = 1'b1;
		@(posedge clk_25m);
		#1;
		cpu_wr = 1'b0;
	endtask

	task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
		@(posedge clk_25m);
		#1;
		cpu_addr = addr;
		cpu_wr   = 1'b0;
		@(negedge clk_25m);
		data = cpu_dout;	// sampled mid cycle away from the edges.
	endtask

	task automatic expect_reg(input logic [15:0] addr, input logic [31:0] exp,
			input string name);
		logic [31:0] got;
		read_reg(addr, got);
		check(name, got, exp);
	endtask

	// highest set bit, scanned from the top.
	function automatic logic [31:0] msb_expect(input logic [31:0] w);
		for (int i = 31; i >= 0; i--) begin
			if (w[i])
				return 32'(i);
		end
		return `MSB_NONE;
	endfunction

	// random 16.16 value in about -8.0 .. +8.0.
	function automatic logic [31:0] small_q16();
		return $urandom_range(0, 32'h000F_FFFF) - 32'h0008_0000;
	endfunction

	// signed dot product of one row scaled back to 16.16.
	function automatic logic [31:0] row_dot(input int r, input int n);
		longint acc;
		acc = 0;
		for (int c = 0; c < n; c++)
			acc += longint'($signed(model_m[r * 4 + c])) * longint'($signed(model_v[c]));
		acc = acc >>> `MATRIX_FRAC_BITS;
		return acc[31:0];
	endfunction

	task automatic check_results();
		for (int i = 0; i < 4; i++)
			expect_reg(`ADDR_REZ_BASE + 16'(4 * i), model_rez[i], $sformatf("rez%0d", i));
	endtask

	task automatic check_all_regs();
		expect_reg(`ADDR_REVISION, `MADAM_REVISION, "revision");
		expect_reg(`ADDR_MSYSBITS, `MADAM_MSYSBITS, "msysbits");
		expect_reg(`ADDR_MCTL, `MADAM_MCTL_RESET, "mctl");
		expect_reg(`ADDR_SLTIME, model_sltime, "sltime");
		expect_reg(`ADDR_MSB_CHECK, msb_expect(model_msb), "msb_check");
		for (int i = 0; i < 4; i++) begin
			expect_reg(`ADDR_REGCTL0 + 16'(4 * i), model_regctl[i], $sformatf("regctl%0d", i));
			expect_reg(`ADDR_VECTOR_BASE + 16'(4 * i), model_v[i], $sformatf("vector%0d", i));
		end
		for (int i = 0; i < 16; i++)
			expect_reg(`ADDR_MATRIX_BASE + 16'(4 * i), model_m[i], $sformatf("matrix%0d", i));
		check_results();
		expect_reg(`ADDR_MATRIX_CMD, 32'd0, "matrix_cmd");
		expect_reg(16'h0010, `MADAM_BAD_READ, "unmapped 0x0010");
		expect_reg(16'h0700, `MADAM_BAD_READ, "unmapped 0x0700");
	endtask

	// random operands for a whole matrix and vector.
	task automatic load_operands();
		for (int i = 0; i < 16; i++) begin
			model_m[i] = small_q16();
			write_reg(`ADDR_MATRIX_BASE + 16'(4 * i), model_m[i]);
		end
		for (int i = 0; i < 4; i++) begin
			model_v[i] = small_q16();
			write_reg(`ADDR_VECTOR_BASE + 16'(4 * i), model_v[i]);
		end
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		int polls;
		polls = 0;
		read_reg(`ADDR_MATRIX_CMD, st);
		while (st != 32'd0 && polls < POLL_LIMIT) begin
			read_reg(`ADDR_MATRIX_CMD, st);
			polls++;
		end
		if (st != 32'd0) begin
			errors++;
			$display("ERROR at %0t ns: matrix engine still busy after %0d polls", $time, polls);
		end
	endtask

	// an accepted command shows busy on the first status read.
	task automatic run_command(input logic [31:0] code, input int n);
		logic [31:0] st;
		write_reg(`ADDR_MATRIX_CMD, code);
		read_reg(`ADDR_MATRIX_CMD, st);
		check("matrix_cmd busy", st, 32'd1);
		wait_idle();
		for (int r = 0; r < n; r++)
			model_rez[r] = row_dot(r, n);
		check_results();
	endtask

	task automatic ignored_command(input logic [31:0] code);
		write_reg(`ADDR_MATRIX_CMD, code);
		expect_reg(`ADDR_MATRIX_CMD, 32'd0, "matrix_cmd after ignored");
		check_results();
	endtask

	initial begin
		int sel;
		logic [31:0] data;
		logic [15:0] addr;
		void'($urandom(50));	// fixed seed for the whole run.
		cpu_addr = '0;
		cpu_din  = '0;
		cpu_wr   = 1'b0;
		reset_n  = 1'b0;
		model_sltime = '0;
		model_msb    = '0;
		for (int i = 0; i < 4; i++) begin
			model_regctl[i] = '0;
			model_v[i]      = '0;
			model_rez[i]    = '0;
		end
		for (int i = 0; i < 16; i++)
			model_m[i] = '0;
		repeat (10) @(posedge clk_25m);
		#1;
		reset_n = 1'b1;

		check_all_regs();	// reset values.

		// random writes with read-back.
		for (int n = 0; n < N_ITER; n++) begin
			sel  = $urandom_range(0, 24);
			data = $urandom();
			if (sel == 0) begin
				addr = `ADDR_SLTIME;
				model_sltime = data;
			end else if (sel < 5) begin
				addr = `ADDR_REGCTL0 + 16'(4 * (sel - 1));
				model_regctl[sel - 1] = data;
			end else if (sel < 21) begin
				addr = `ADDR_MATRIX_BASE + 16'(4 * (sel - 5));
				model_m[sel - 5] = data;
			end else begin
				addr = `ADDR_VECTOR_BASE + 16'(4 * (sel - 21));
				model_v[sel - 21] = data;
			end
			write_reg(addr, data);
			expect_reg(addr, data, $sformatf("read-back 0x%04h", addr));
		end
		// read-only and unmapped writes are dropped.
		write_reg(`ADDR_REVISION, $urandom());
		write_reg(`ADDR_MSYSBITS, $urandom());
		write_reg(`ADDR_MCTL, $urandom());
		write_reg(16'h0010, $urandom());
		write_reg(16'h0200, $urandom());
		write_reg(16'h0700, $urandom());
		check_all_regs();

		// msb finder.
		for (int k = 0; k < 32 + N_ITER; k++) begin
			model_msb = (k < 32) ? (32'd1 << k) : ($urandom() >> $urandom_range(0, 31));
			write_reg(`ADDR_MSB_CHECK, model_msb);
			expect_reg(`ADDR_MSB_CHECK, msb_expect(model_msb), "msb_check");
		end
		model_msb = '0;
		write_reg(`ADDR_MSB_CHECK, model_msb);
		expect_reg(`ADDR_MSB_CHECK, `MSB_NONE, "msb_check zero");

		// mul4 then a mul3 that keeps rez3.
		for (int n = 0; n < MUL_ROUNDS; n++) begin
			load_operands();
			run_command(32'd1, 4);
			load_operands();
			run_command(32'd2, 3);
		end

		// nop, persp and a command while busy are all dropped.
		ignored_command(32'd0);
		ignored_command(32'd3);
		load_operands();
		write_reg(`ADDR_MATRIX_CMD, 32'd1);
		write_reg(`ADDR_MATRIX_CMD, 32'd2);	// lands while busy.
		wait_idle();
		for (int r = 0; r < 4; r++)
			model_rez[r] = row_dot(r, 4);
		check_results();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog.
	initial begin
		#(CLK_PERIOD * TIMEOUT_CYCLES);
		$display("ERROR: watchdog timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule
